// ==== rtl/credit_egress.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_egress (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              in_empty_i,
  input  logic [stencil_pkg::OUT_CNT_W-1:0] out_count_i,
  input  logic                              out_empty_i,
  input  logic                              retire_i,
  input  logic                              out_credit_i,
  output logic                              advance_o,
  output logic                              out_pop_o,
  output logic                              out_valid_o
);

  import stencil_pkg::*;

  logic [OUT_CNT_W-1:0] inflight_q;
  logic [DS_CNT_W-1:0]  ds_credits_q;
  logic [OUT_CNT_W:0]   reserved;

  // Every admitted pixel reserves an output slot until it retires.
  assign reserved  = (OUT_CNT_W + 1)'(out_count_i) + (OUT_CNT_W + 1)'(inflight_q);
  assign advance_o = !in_empty_i && (reserved < (OUT_CNT_W + 1)'(OUT_DEPTH));

  assign out_pop_o   = (ds_credits_q != '0) && !out_empty_i;
  // Popped head is on the output in the same cycle.
  assign out_valid_o = out_pop_o;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inflight_q   <= '0;
      ds_credits_q <= DS_CNT_W'(DS_CREDITS);
    end else begin
      inflight_q   <= inflight_q + OUT_CNT_W'(advance_o) - OUT_CNT_W'(retire_i);
      ds_credits_q <= ds_credits_q + DS_CNT_W'(out_credit_i) - DS_CNT_W'(out_pop_o);
    end
  end

  a_ds_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    ds_credits_q <= DS_CNT_W'(DS_CREDITS))
    else $error("credit_egress: receiver returned more credits than granted");

  a_retire_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
    retire_i |-> inflight_q != '0)
    else $error("credit_egress: filter retired a pixel that was never admitted");

endmodule

`default_nettype wire

// ==== rtl/credit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
  parameter type item_t = logic,
  parameter int  DEPTH  = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       push_i,
  input  item_t                      data_i,
  input  logic                       pop_i,
  output item_t                      data_o,
  output logic                       empty_o,
  output logic [$clog2(DEPTH+1)-1:0] count_o,
  output logic                       credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full    = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign count_o = count_q;
  // Show-ahead head.
  assign data_o  = mem[rd_ptr_q];

  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      credit_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      count_q  <= count_q + CNT_W'(push_i) - CNT_W'(pop_i);
      // One credit back to the writer per freed slot.
      credit_o <= pop_i;
    end
  end

  a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n) push_i |-> !full)
    else $error("credit_fifo: push while full, writer exceeded its credits");

  a_no_underrun: assert property (@(posedge clk) disable iff (!rst_n) pop_i |-> !empty_o)
    else $error("credit_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== rtl/line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_buffer (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               advance_i,
  input  stencil_pkg::pixel_t                pix_i,
  input  logic [stencil_pkg::IMG_SIZE_W-1:0] img_size_i,
  output stencil_pkg::column_t               col_o,
  output logic                               col_valid_o,
  output logic                               sof_o
);

  import stencil_pkg::*;

  localparam int LINES = WIN - 1;

  // Line 0 holds the previous row, line 7 the row eight rows up.
  logic [PIX_W-1:0] line_mem [LINES][MAX_IMG_W];
  logic [COL_W-1:0] col_q;
  logic [COL_W-1:0] cur_col;
  logic             last_col;

  // A start-of-frame pixel always sits in column 0.
  assign cur_col  = pix_i.sof ? '0 : col_q;
  assign last_col = (IMG_SIZE_W'(cur_col) == img_size_i - IMG_SIZE_W'(1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
    end else if (advance_i) begin
      col_q <= last_col ? '0 : cur_col + 1'b1;
    end
  end

  // Each line passes its old pixel one line further up.
  always_ff @(posedge clk) begin
    if (advance_i) begin
      line_mem[0][cur_col] <= pix_i.data;
      for (int k = 1; k < LINES; k++) begin
        line_mem[k][cur_col] <= line_mem[k-1][cur_col];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (advance_i) begin
      col_o[WIN-1] <= pix_i.data;
      for (int k = 0; k < LINES; k++) begin
        col_o[LINES-1-k] <= line_mem[k][cur_col];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_valid_o <= 1'b0;
      sof_o       <= 1'b0;
    end else begin
      col_valid_o <= advance_i;
      sof_o       <= advance_i & pix_i.sof;
    end
  end

  a_img_size: assert property (@(posedge clk) disable iff (!rst_n)
    advance_i |-> (img_size_i >= IMG_SIZE_W'(WIN)) && (img_size_i <= IMG_SIZE_W'(MAX_IMG_W)))
    else $error("line_buffer: image side %0d out of range", img_size_i);

endmodule

`default_nettype wire

// ==== rtl/stencil_pkg.sv ====
`default_nettype none

package stencil_pkg;

  localparam int PIX_W      = 8;
  localparam int WIN        = 9;
  localparam int MAX_IMG_W  = 64;
  localparam int SUM_W      = 15;
  localparam int IMG_SIZE_W = 9;
  localparam int COL_W      = $clog2(MAX_IMG_W);
  localparam int COL_SUM_W  = PIX_W + $clog2(WIN);

  // Credit and queue sizing.
  localparam int IN_CREDITS = 4;
  localparam int OUT_DEPTH  = 8;
  localparam int DS_CREDITS = 4;
  localparam int OUT_CNT_W  = $clog2(OUT_DEPTH + 1);
  localparam int DS_CNT_W   = $clog2(DS_CREDITS + 1);

  typedef struct packed {
    logic             sof;
    logic [PIX_W-1:0] data;
  } pixel_t;

  // Index 0 is the oldest row.
  typedef logic [WIN-1:0][PIX_W-1:0] column_t;

  // Index 0 is the oldest column.
  typedef column_t [WIN-1:0] window_t;

  typedef struct packed {
    logic [SUM_W-1:0] sum;
    logic [PIX_W-1:0] max;
  } result_t;

endpackage

`default_nettype wire

// ==== rtl/stencil_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module stencil_top (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic [stencil_pkg::IMG_SIZE_W-1:0] img_size_i,
  input  logic                               in_valid_i,
  input  stencil_pkg::pixel_t                in_pix_i,
  output logic                               in_credit_o,
  input  logic                               out_credit_i,
  output logic                               out_valid_o,
  output stencil_pkg::result_t               out_res_o
);

  import stencil_pkg::*;

  pixel_t               in_head;
  logic                 in_empty;
  logic                 advance;
  column_t              col;
  logic                 col_valid;
  logic                 col_sof;
  window_t              win;
  logic                 win_valid;
  logic                 win_complete;
  logic                 retire;
  logic                 res_valid;
  result_t              res;
  logic                 out_empty;
  logic [OUT_CNT_W-1:0] out_count;
  logic                 out_pop;

  credit_fifo #(
    .item_t (pixel_t),
    .DEPTH  (IN_CREDITS)
  ) in_fifo_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .push_i   (in_valid_i),
    .data_i   (in_pix_i),
    .pop_i    (advance),
    .data_o   (in_head),
    .empty_o  (in_empty),
    .count_o  (),
    .credit_o (in_credit_o)
  );

  line_buffer line_buffer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .advance_i   (advance),
    .pix_i       (in_head),
    .img_size_i  (img_size_i),
    .col_o       (col),
    .col_valid_o (col_valid),
    .sof_o       (col_sof)
  );

  window_buffer window_buffer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .col_valid_i    (col_valid),
    .col_i          (col),
    .sof_i          (col_sof),
    .img_size_i     (img_size_i),
    .win_o          (win),
    .win_valid_o    (win_valid),
    .win_complete_o (win_complete)
  );

  window_filter window_filter_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .win_valid_i    (win_valid),
    .win_complete_i (win_complete),
    .win_i          (win),
    .retire_o       (retire),
    .res_valid_o    (res_valid),
    .res_o          (res)
  );

  credit_fifo #(
    .item_t (result_t),
    .DEPTH  (OUT_DEPTH)
  ) out_fifo_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .push_i   (res_valid),
    .data_i   (res),
    .pop_i    (out_pop),
    .data_o   (out_res_o),
    .empty_o  (out_empty),
    .count_o  (out_count),
    .credit_o ()
  );

  credit_egress credit_egress_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_empty_i   (in_empty),
    .out_count_i  (out_count),
    .out_empty_i  (out_empty),
    .retire_i     (retire),
    .out_credit_i (out_credit_i),
    .advance_o    (advance),
    .out_pop_o    (out_pop),
    .out_valid_o  (out_valid_o)
  );

endmodule

`default_nettype wire

// ==== rtl/window_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_buffer (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               col_valid_i,
  input  stencil_pkg::column_t               col_i,
  input  logic                               sof_i,
  input  logic [stencil_pkg::IMG_SIZE_W-1:0] img_size_i,
  output stencil_pkg::window_t               win_o,
  output logic                               win_valid_o,
  output logic                               win_complete_o
);

  import stencil_pkg::*;

  logic [COL_W-1:0] col_q;
  logic [COL_W-1:0] row_q;
  logic [COL_W-1:0] cur_col;
  logic [COL_W-1:0] cur_row;
  logic             last_col;
  logic             last_row;
  logic             complete;

  // Position of the pixel whose column arrives now.
  assign cur_col  = sof_i ? '0 : col_q;
  assign cur_row  = sof_i ? '0 : row_q;
  assign last_col = (IMG_SIZE_W'(cur_col) == img_size_i - IMG_SIZE_W'(1));
  assign last_row = (IMG_SIZE_W'(cur_row) == img_size_i - IMG_SIZE_W'(1));

  // Needs eight earlier rows and eight earlier columns of this frame.
  assign complete = (cur_col >= COL_W'(WIN - 1)) && (cur_row >= COL_W'(WIN - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_q <= '0;
      row_q <= '0;
    end else if (col_valid_i) begin
      if (last_col) begin
        col_q <= '0;
        row_q <= last_row ? '0 : cur_row + 1'b1;
      end else begin
        col_q <= cur_col + 1'b1;
        row_q <= cur_row;
      end
    end
  end

  // Newest column enters at the top index.
  always_ff @(posedge clk) begin
    if (col_valid_i) begin
      for (int k = 0; k < WIN - 1; k++) begin
        win_o[k] <= win_o[k+1];
      end
      win_o[WIN-1] <= col_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid_o    <= 1'b0;
      win_complete_o <= 1'b0;
    end else begin
      win_valid_o    <= col_valid_i;
      win_complete_o <= col_valid_i & complete;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/window_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_filter (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 win_valid_i,
  input  logic                 win_complete_i,
  input  stencil_pkg::window_t win_i,
  output logic                 retire_o,
  output logic                 res_valid_o,
  output stencil_pkg::result_t res_o
);

  import stencil_pkg::*;

  logic [COL_SUM_W-1:0] col_sum_d [WIN];
  logic [PIX_W-1:0]     col_max_d [WIN];
  logic [COL_SUM_W-1:0] col_sum_q [WIN];
  logic [PIX_W-1:0]     col_max_q [WIN];
  logic                 valid_q;
  logic                 complete_q;
  logic [SUM_W-1:0]     win_sum;
  logic [PIX_W-1:0]     win_max;

  // Stage 1 reduces each column.
  always_comb begin
    for (int j = 0; j < WIN; j++) begin
      col_sum_d[j] = '0;
      col_max_d[j] = '0;
      for (int i = 0; i < WIN; i++) begin
        col_sum_d[j] = col_sum_d[j] + COL_SUM_W'(win_i[j][i]);
        if (win_i[j][i] > col_max_d[j]) begin
          col_max_d[j] = win_i[j][i];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < WIN; j++) begin
      col_sum_q[j] <= col_sum_d[j];
      col_max_q[j] <= col_max_d[j];
    end
  end

  // Stage 2 combines the nine column partials.
  always_comb begin
    win_sum = '0;
    win_max = '0;
    for (int j = 0; j < WIN; j++) begin
      win_sum = win_sum + SUM_W'(col_sum_q[j]);
      if (col_max_q[j] > win_max) begin
        win_max = col_max_q[j];
      end
    end
  end

  always_ff @(posedge clk) begin
    res_o.sum <= win_sum;
    res_o.max <= win_max;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q     <= 1'b0;
      complete_q  <= 1'b0;
      retire_o    <= 1'b0;
      res_valid_o <= 1'b0;
    end else begin
      valid_q     <= win_valid_i;
      complete_q  <= win_valid_i & win_complete_i;
      retire_o    <= valid_q;
      res_valid_o <= complete_q;
    end
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verification
rtl/stencil_pkg.sv
rtl/credit_fifo.sv
rtl/line_buffer.sv
rtl/window_buffer.sv
rtl/window_filter.sv
rtl/credit_egress.sv
rtl/stencil_top.sv
verification/stencil_tb.sv

// ==== verification/stencil_ref.svh ====
`ifndef STENCIL_REF_SVH
`define STENCIL_REF_SVH

// Pixels of the frame most recently generated, row after row.
logic [PIX_W-1:0] frame_mem [MAX_IMG_W*MAX_IMG_W];

// Sum and max of the 9x9 window whose newest pixel is at row r, column c.
function automatic result_t window_ref(input int n, input int r, input int c);
  result_t res;
  int      sum;
  int      max_val;
  sum     = 0;
  max_val = 0;
  for (int y = r - WIN + 1; y <= r; y++) begin
    for (int x = c - WIN + 1; x <= c; x++) begin
      sum = sum + int'(frame_mem[y*n + x]);
      if (int'(frame_mem[y*n + x]) > max_val) begin
        max_val = int'(frame_mem[y*n + x]);
      end
    end
  end
  res.sum = SUM_W'(sum);
  res.max = PIX_W'(max_val);
  return res;
endfunction

// Queues one n x n frame for upstream and its results in raster order.
// A negative value gives random pixels.
task automatic gen_frame(input int n, input int value);
  pixel_t pix;
  for (int i = 0; i < n*n; i++) begin
    frame_mem[i] = (value < 0) ? PIX_W'($random(seed)) : PIX_W'(value);
    pix.sof      = (i == 0);
    pix.data     = frame_mem[i];
    send_q.push_back(pix);
  end
  // Only pixels with eight rows and eight columns before them complete a window.
  for (int r = WIN - 1; r < n; r++) begin
    for (int c = WIN - 1; c < n; c++) begin
      exp_q.push_back(window_ref(n, r, c));
    end
  end
endtask

`endif

// ==== verification/stencil_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module stencil_tb;

  import stencil_pkg::*;

  localparam int TOTAL_PIX = 12*12 + 9*9 + 12*12 + 10*10 + 16*16;
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_PIX + 1000;

  logic                  clk;
  logic                  rst_n;
  logic [IMG_SIZE_W-1:0] img_size_i;
  logic                  in_valid_i;
  pixel_t                in_pix_i;
  logic                  in_credit_o;
  logic                  out_credit_i;
  logic                  out_valid_o;
  result_t               out_res_o;

  integer  seed;
  pixel_t  send_q[$];
  result_t exp_q[$];
  string   test_name = "reset";
  int      up_credits = IN_CREDITS;
  int      sent = 0;
  int      credit_pulses = 0;
  int      results_seen = 0;
  int      owed = 0;
  int      hold_left = 0;
  int      return_gap = 0;
  int      gap_left = 0;
  int      early_size = 12;
  int      late_size = 12;
  int      size_switch_at = 0;
  bit      credit_returned = 1'b0;
  int      early_results = 0;
  int      result_base = 0;
  int      error_base = 0;
  int      errors = 0;
  int      checks = 0;
  int      tests = 0;

  `include "stencil_ref.svh"

  stencil_top stencil_top_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .img_size_i   (img_size_i),
    .in_valid_i   (in_valid_i),
    .in_pix_i     (in_pix_i),
    .in_credit_o  (in_credit_o),
    .out_credit_i (out_credit_i),
    .out_valid_o  (out_valid_o),
    .out_res_o    (out_res_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic compare_result(input string name, input result_t exp, input result_t act);
    checks++;
    if (exp !== act) begin
      $display("[ERROR] %s: expected sum %0d max %0d, actual sum %0d max %0d",
               name, exp.sum, exp.max, act.sum, act.max);
      errors++;
    end
  endtask

  task automatic compare_count(input string name, input int exp, input int act);
    checks++;
    if (exp != act) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      errors++;
    end
  endtask

  task automatic begin_test(input string name, input int first_size, input int second_size,
                            input int switch_after, input int hold, input int gap);
    @(negedge clk);
    test_name       = name;
    error_base      = errors;
    result_base     = results_seen;
    early_size      = first_size;
    late_size       = second_size;
    size_switch_at  = credit_pulses + switch_after;
    hold_left       = hold;
    return_gap      = gap;
    gap_left        = 0;
    credit_returned = 1'b0;
    early_results   = 0;
  endtask

  task automatic finish_test(input int expected, input bit check_early);
    while (send_q.size() != 0 || exp_q.size() != 0 || owed != 0) begin
      @(negedge clk);
    end
    // Room for any stray result to show up.
    repeat (8) @(negedge clk);
    if (check_early) begin
      compare_count({test_name, " results before credit"}, DS_CREDITS, early_results);
    end
    compare_count({test_name, " result count"}, expected, results_seen - result_base);
    tests++;
    $display("%-14s %s, %0d results", test_name, (errors == error_base) ? "ok" : "FAILED",
             results_seen - result_base);
  endtask

  // Upstream sends against its credits, downstream returns one credit per result.
  always @(posedge clk) begin
    img_size_i <= IMG_SIZE_W'((credit_pulses >= size_switch_at) ? late_size : early_size);
    if (up_credits > 0 && send_q.size() != 0) begin
      in_valid_i <= 1'b1;
      in_pix_i   <= send_q.pop_front();
      up_credits--;
      sent++;
    end else begin
      in_valid_i <= 1'b0;
    end
    if (hold_left > 0) begin
      hold_left--;
      out_credit_i <= 1'b0;
    end else if (owed > 0 && gap_left == 0) begin
      out_credit_i <= 1'b1;
      owed--;
      gap_left = return_gap;
      if (!credit_returned) begin
        credit_returned = 1'b1;
        early_results   = results_seen - result_base;
      end
    end else begin
      out_credit_i <= 1'b0;
      if (gap_left > 0) begin
        gap_left--;
      end
    end
  end

  always @(negedge clk) begin
    if (in_credit_o === 1'b1) begin
      credit_pulses++;
      up_credits++;
    end
    if (up_credits > IN_CREDITS) begin
      $display("%s: upstream holds %0d credits, more than the %0d it was granted",
               test_name, up_credits, IN_CREDITS);
      errors++;
    end
    if (out_valid_o === 1'b1) begin
      results_seen++;
      owed++;
      if (exp_q.size() == 0) begin
        $display("%s: a result arrived when none was expected", test_name);
        errors++;
      end else begin
        compare_result(test_name, exp_q.pop_front(), out_res_o);
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired in %s with %0d results still expected", test_name,
             exp_q.size());
    $display("sim failed");
    $finish;
  end

  initial begin
    seed = 32'h91335130;
    rst_n        <= 1'b0;
    img_size_i   <= IMG_SIZE_W'(12);
    in_valid_i   <= 1'b0;
    in_pix_i     <= '0;
    out_credit_i <= 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    if (in_credit_o !== 1'b0 || out_valid_o !== 1'b0) begin
      $display("in_credit_o or out_valid_o is not low after reset");
      errors++;
    end

    begin_test("random_12", 12, 12, 0, 0, 0);
    gen_frame(12, -1);
    finish_test(16, 1'b0);

    begin_test("flat_9", 9, 9, 0, 0, 0);
    gen_frame(9, 255);
    finish_test(1, 1'b0);

    begin_test("credit_stall", 12, 12, 0, 200, 6);
    gen_frame(12, -1);
    finish_test(16, 1'b1);

    // Side changes once frame one is into its last row.
    begin_test("back_to_back", 10, 16, 95, 0, 0);
    gen_frame(10, -1);
    gen_frame(16, -1);
    finish_test(68, 1'b0);

    begin_test("credit_balance", 12, 12, 0, 0, 0);
    compare_count("credit_balance credit pulses", sent, credit_pulses);
    finish_test(0, 1'b0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
